/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = tb_l1_icache
FILELIST = sim.f
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* hdl/cache_pkg.sv */
// ======================================================================
// L1 instruction cache shared definitions
// ======================================================================
`default_nettype none

package cache_pkg;

  // address width seen by the fetch stage
  localparam int L0_ADDR_BITS = 64;

  // default geometry: 4 ways, 64 byte lines, 4 KiB, so 16 sets
  localparam int DEF_WAYS = 4;
  localparam int DEF_BLOCK_BYTES = 64;
  localparam int DEF_CAPACITY = 4096;
  localparam int DEF_PADDR_BITS = 32;

  // controller states
  // a hit walks idle, lookup, check, respond
  // a miss walks idle, lookup, check, miss_req, miss_wait, fill, respond
  typedef enum logic [2:0] {
    idle,
    lookup,
    check,
    miss_req,
    miss_wait,
    fill,
    respond
  } l1_state_e;

endpackage : cache_pkg

`default_nettype wire

/* hdl/cache_store_if.sv */
// ======================================================================
// Controller to storage interface
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

interface cache_store_if #(
  parameter int A,
  parameter int B,
  parameter int C,
  parameter int PADDR_BITS
);

  localparam int SETS = C / (A * B);
  localparam int OFFSET_BITS = $clog2(B);
  localparam int INDEX_BITS = $clog2(SETS);
  localparam int TAG_BITS = PADDR_BITS - OFFSET_BITS - INDEX_BITS;
  // addresses on this interface are line addresses, {tag, index}
  localparam int LA_BITS = TAG_BITS + INDEX_BITS;

  // lookup pulse, answered one cycle later
  logic lookup_valid;
  logic [LA_BITS-1:0] lookup_addr;
  logic result_valid;
  logic result_hit;
  logic [8*B-1:0] result_line;

  // fill pulse, written at the same edge
  logic fill_valid;
  logic [LA_BITS-1:0] fill_addr;
  logic [8*B-1:0] fill_line;

  logic invalidate_all;

  modport ctrl (
    output lookup_valid, lookup_addr, fill_valid, fill_addr, fill_line, invalidate_all,
    input result_valid, result_hit, result_line
  );

  modport store (
    input lookup_valid, lookup_addr, fill_valid, fill_addr, fill_line, invalidate_all,
    output result_valid, result_hit, result_line
  );

endinterface : cache_store_if

`default_nettype wire

/* hdl/l1_icache_top.sv */
// ======================================================================
// L1 instruction cache top level
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module l1_icache_top #(
  parameter int A = cache_pkg::DEF_WAYS,
  parameter int B = cache_pkg::DEF_BLOCK_BYTES,
  parameter int C = cache_pkg::DEF_CAPACITY,
  parameter int PADDR_BITS = cache_pkg::DEF_PADDR_BITS
) (
  input logic clk_in,
  input logic rst_N_in,
  input logic flush_in,

  input logic l0_valid_in,
  input logic [cache_pkg::L0_ADDR_BITS-1:0] l0_addr_in,
  output logic l0_ready_out,

  output logic l0_valid_out,
  output logic [cache_pkg::L0_ADDR_BITS-1:0] l0_addr_out,
  output logic [8*B-1:0] l0_value_out,
  input logic l0_ready_in,

  output logic lc_valid_out,
  output logic [PADDR_BITS-1:0] lc_addr_out,
  input logic lc_ready_in,

  input logic lc_valid_in,
  input logic [PADDR_BITS-1:0] lc_addr_in,
  input logic [8*B-1:0] lc_value_in,
  output logic lc_ready_out
);

  cache_store_if #(
    .A(A),
    .B(B),
    .C(C),
    .PADDR_BITS(PADDR_BITS)
  ) store_bus ();

  // controller owns both handshakes
  l1_instr_cache #(
    .A(A),
    .B(B),
    .C(C),
    .PADDR_BITS(PADDR_BITS)
  ) u_ctrl (
    .clk_in(clk_in),
    .rst_N_in(rst_N_in),
    .flush_in(flush_in),
    .l0_valid_in(l0_valid_in),
    .l0_addr_in(l0_addr_in),
    .l0_ready_out(l0_ready_out),
    .l0_valid_out(l0_valid_out),
    .l0_addr_out(l0_addr_out),
    .l0_value_out(l0_value_out),
    .l0_ready_in(l0_ready_in),
    .lc_valid_out(lc_valid_out),
    .lc_addr_out(lc_addr_out),
    .lc_ready_in(lc_ready_in),
    .lc_valid_in(lc_valid_in),
    .lc_addr_in(lc_addr_in),
    .lc_value_in(lc_value_in),
    .lc_ready_out(lc_ready_out),
    .store(store_bus)
  );

  set_assoc_store #(
    .A(A),
    .B(B),
    .C(C),
    .PADDR_BITS(PADDR_BITS)
  ) u_store (
    .clk_in(clk_in),
    .rst_N_in(rst_N_in),
    .store(store_bus)
  );

endmodule : l1_icache_top

`default_nettype wire

/* hdl/l1_instr_cache.sv */
// ======================================================================
// L1 instruction cache controller
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module l1_instr_cache #(
  parameter int A,
  parameter int B,
  parameter int C,
  parameter int PADDR_BITS
) (
  input logic clk_in,
  input logic rst_N_in,
  input logic flush_in,

  // request from L0
  input logic l0_valid_in,
  input logic [cache_pkg::L0_ADDR_BITS-1:0] l0_addr_in,
  output logic l0_ready_out,

  // response to L0
  output logic l0_valid_out,
  output logic [cache_pkg::L0_ADDR_BITS-1:0] l0_addr_out,
  output logic [8*B-1:0] l0_value_out,
  input logic l0_ready_in,

  // miss request to the lower cache
  output logic lc_valid_out,
  output logic [PADDR_BITS-1:0] lc_addr_out,
  input logic lc_ready_in,

  // line returned by the lower cache
  input logic lc_valid_in,
  input logic [PADDR_BITS-1:0] lc_addr_in,
  input logic [8*B-1:0] lc_value_in,
  output logic lc_ready_out,

  cache_store_if.ctrl store
);

  localparam int SETS = C / (A * B);
  localparam int OFFSET_BITS = $clog2(B);
  localparam int INDEX_BITS = $clog2(SETS);
  localparam int TAG_BITS = PADDR_BITS - OFFSET_BITS - INDEX_BITS;
  localparam int LA_BITS = TAG_BITS + INDEX_BITS;
  localparam int LINE_BITS = 8 * B;

  cache_pkg::l1_state_e state_q;

  logic l0_valid_q;
  logic lc_valid_q;
  logic lc_ready_q;
  logic accept;

  // payload registers
  logic [cache_pkg::L0_ADDR_BITS-1:0] addr_q;
  logic [LINE_BITS-1:0] line_q;
  logic [LA_BITS-1:0] fill_addr_q;

  // ready only in idle, and a pending flush blocks new requests
  assign l0_ready_out = (state_q == cache_pkg::idle) && !flush_in;
  assign accept = l0_valid_in && l0_ready_out;

  // timing, counted in edges after the accepting edge:
  // lc_valid_out register rises at edge 2 on a miss,
  // l0_valid_out register rises at edge 3 on a hit
  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state_q <= cache_pkg::idle;
      l0_valid_q <= 1'b0;
      lc_valid_q <= 1'b0;
      lc_ready_q <= 1'b0;
    end else begin
      case (state_q)
        cache_pkg::idle: begin
          if (accept) begin
            state_q <= cache_pkg::lookup;
          end
        end
        cache_pkg::lookup: begin
          state_q <= cache_pkg::check;
        end
        cache_pkg::check: begin
          if (store.result_valid) begin
            if (store.result_hit) begin
              state_q <= cache_pkg::respond;
            end else begin
              lc_valid_q <= 1'b1;
              state_q <= cache_pkg::miss_req;
            end
          end
        end
        cache_pkg::miss_req: begin
          // request held until the lower cache takes it
          if (lc_ready_in) begin
            lc_valid_q <= 1'b0;
            lc_ready_q <= 1'b1;
            state_q <= cache_pkg::miss_wait;
          end
        end
        cache_pkg::miss_wait: begin
          if (lc_valid_in) begin
            lc_ready_q <= 1'b0;
            state_q <= cache_pkg::fill;
          end
        end
        cache_pkg::fill: begin
          l0_valid_q <= 1'b1;
          state_q <= cache_pkg::respond;
        end
        cache_pkg::respond: begin
          // hit path raises valid here, miss path already has it up
          if (!l0_valid_q) begin
            l0_valid_q <= 1'b1;
          end else if (l0_ready_in) begin
            l0_valid_q <= 1'b0;
            state_q <= cache_pkg::idle;
          end
        end
        default: begin
          state_q <= cache_pkg::idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    // keep only the line-aligned address
    if (accept) begin
      addr_q <= {l0_addr_in[cache_pkg::L0_ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    end
    if ((state_q == cache_pkg::check) && store.result_valid && store.result_hit) begin
      line_q <= store.result_line;
    end
    // the returned line both fills the storage and answers L0
    if ((state_q == cache_pkg::miss_wait) && lc_valid_in) begin
      line_q <= lc_value_in;
      fill_addr_q <= lc_addr_in[OFFSET_BITS +: LA_BITS];
    end
  end

  assign l0_valid_out = l0_valid_q;
  assign l0_addr_out = addr_q;
  assign l0_value_out = line_q;

  assign lc_valid_out = lc_valid_q;
  assign lc_addr_out = addr_q[PADDR_BITS-1:0];
  assign lc_ready_out = lc_ready_q;

  // storage side
  assign store.lookup_valid = (state_q == cache_pkg::lookup);
  assign store.lookup_addr = addr_q[OFFSET_BITS +: LA_BITS];
  assign store.fill_valid = (state_q == cache_pkg::fill);
  assign store.fill_addr = fill_addr_q;
  assign store.fill_line = line_q;
  assign store.invalidate_all = (state_q == cache_pkg::idle) && flush_in;

endmodule : l1_instr_cache

`default_nettype wire

/* hdl/set_assoc_store.sv */
// ======================================================================
// Set-associative line storage with LRU
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module set_assoc_store #(
  parameter int A,
  parameter int B,
  parameter int C,
  parameter int PADDR_BITS
) (
  input logic clk_in,
  input logic rst_N_in,
  cache_store_if.store store
);

  localparam int SETS = C / (A * B);
  localparam int OFFSET_BITS = $clog2(B);
  localparam int INDEX_BITS = $clog2(SETS);
  localparam int TAG_BITS = PADDR_BITS - OFFSET_BITS - INDEX_BITS;
  localparam int LINE_BITS = 8 * B;
  // ages double as way numbers, so both share one width
  localparam int AGE_BITS = (A > 1) ? $clog2(A) : 1;

  // age 0 is most recently used, age A-1 is the LRU way
  logic [TAG_BITS-1:0] tag_q [SETS][A];
  logic [LINE_BITS-1:0] data_q [SETS][A];
  logic [AGE_BITS-1:0] age_q [SETS][A];
  logic [A-1:0] valid_q [SETS];

  logic [INDEX_BITS-1:0] lk_index;
  logic [TAG_BITS-1:0] lk_tag;
  logic [INDEX_BITS-1:0] fill_index;
  logic [TAG_BITS-1:0] fill_tag;

  logic hit;
  logic [AGE_BITS-1:0] hit_way;
  logic found_free;
  logic [AGE_BITS-1:0] victim;

  logic touch_valid;
  logic [INDEX_BITS-1:0] touch_set;
  logic [AGE_BITS-1:0] touch_way;
  logic [AGE_BITS-1:0] touch_age;

  // line address is {tag, index}
  assign lk_index = store.lookup_addr[INDEX_BITS-1:0];
  assign lk_tag = store.lookup_addr[INDEX_BITS +: TAG_BITS];
  assign fill_index = store.fill_addr[INDEX_BITS-1:0];
  assign fill_tag = store.fill_addr[INDEX_BITS +: TAG_BITS];

  // all ways of the set compared in parallel
  always_comb begin
    hit = 1'b0;
    hit_way = '0;
    for (int w = 0; w < A; w++) begin
      if (valid_q[lk_index][w] && (tag_q[lk_index][w] == lk_tag)) begin
        hit = 1'b1;
        hit_way = AGE_BITS'(w);
      end
    end
  end

  // victim: lowest invalid way first, else the oldest way
  always_comb begin
    found_free = 1'b0;
    victim = '0;
    for (int w = 0; w < A; w++) begin
      if (!found_free && !valid_q[fill_index][w]) begin
        found_free = 1'b1;
        victim = AGE_BITS'(w);
      end
    end
    if (!found_free) begin
      for (int w = 0; w < A; w++) begin
        if (age_q[fill_index][w] == AGE_BITS'(A - 1)) begin
          victim = AGE_BITS'(w);
        end
      end
    end
  end

  // a fill and a hit never share a cycle; fill wins anyway
  assign touch_valid = store.fill_valid || (store.lookup_valid && hit);
  assign touch_set = store.fill_valid ? fill_index : lk_index;
  assign touch_way = store.fill_valid ? victim : hit_way;
  assign touch_age = age_q[touch_set][touch_way];

  // valid bits, ages and result flags
  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      for (int s = 0; s < SETS; s++) begin
        valid_q[s] <= '0;
        for (int w = 0; w < A; w++) begin
          age_q[s][w] <= AGE_BITS'(w);
        end
      end
      store.result_valid <= 1'b0;
      store.result_hit <= 1'b0;
    end else begin
      store.result_valid <= store.lookup_valid;
      store.result_hit <= store.lookup_valid && hit;

      // touched way becomes youngest, younger ways age by one
      if (touch_valid) begin
        for (int w = 0; w < A; w++) begin
          if (AGE_BITS'(w) == touch_way) begin
            age_q[touch_set][w] <= '0;
          end else if (age_q[touch_set][w] < touch_age) begin
            age_q[touch_set][w] <= age_q[touch_set][w] + 1'b1;
          end
        end
      end

      if (store.fill_valid) begin
        valid_q[fill_index][victim] <= 1'b1;
      end

      // flush clears everything, ages keep their order
      if (store.invalidate_all) begin
        for (int s = 0; s < SETS; s++) begin
          valid_q[s] <= '0;
        end
      end
    end
  end

  // tags, lines and the registered read port
  always_ff @(posedge clk_in) begin
    if (store.lookup_valid) begin
      store.result_line <= data_q[lk_index][hit_way];
    end
    if (store.fill_valid) begin
      data_q[fill_index][victim] <= store.fill_line;
      tag_q[fill_index][victim] <= fill_tag;
    end
  end

endmodule : set_assoc_store

`default_nettype wire

/* sim.f */
hdl/cache_pkg.sv
hdl/cache_store_if.sv
hdl/set_assoc_store.sv
hdl/l1_instr_cache.sv
hdl/l1_icache_top.sv
tb/l1_icache_properties.sv
tb/l1_icache_checker.sv
tb/tb_l1_icache.sv

/* tb/l1_icache_checker.sv */
// ======================================================================
// Response checker with reference LRU model
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module l1_icache_checker #(
  parameter int LINE_BITS = 512,
  parameter int PADDR_BITS = 32
) (
  input logic clk_in,
  input logic rst_N_in,
  input logic flush_in,
  input logic l0_valid_in,
  input logic [cache_pkg::L0_ADDR_BITS-1:0] l0_addr_in,
  input logic l0_ready_out,
  input logic l0_valid_out,
  input logic [cache_pkg::L0_ADDR_BITS-1:0] l0_addr_out,
  input logic [LINE_BITS-1:0] l0_value_out,
  input logic l0_ready_in,
  input logic lc_valid_out,
  input logic [PADDR_BITS-1:0] lc_addr_out,
  input logic lc_ready_in,
  input logic lc_valid_in,
  input logic lc_ready_out,
  output int pass_count,
  output int fail_count
);

  // model: 16 sets, 4 ways, slot 0 is most recently used
  logic [31:0] lines [16][4];
  bit present [16][4];

  string cur_name;
  bit tbl_hit;
  bit in_flight;
  bit pred_hit;
  logic [31:0] req_line;
  logic [31:0] lc_seen;
  int cycles;
  int rise_lat;
  int lc_reqs;
  bit lc_addr_ok;
  bit lc_prev;
  bit lc_waiting;
  bit lc_rdy_bad;
  bit lc_rdy_exp;

  function automatic logic [LINE_BITS-1:0] pattern_line(input logic [31:0] line_addr);
    logic [LINE_BITS-1:0] v;
    for (int k = 0; k < LINE_BITS / 64; k++) begin
      v[64*k +: 64] = {line_addr, 32'(k)};
    end
    return v;
  endfunction

  // move the line to slot 0, dropping the last slot on a miss
  task automatic model_access(input logic [31:0] line, output bit hit);
    int set;
    int pos;
    set = int'(line[9:6]);
    pos = 3;
    hit = 1'b0;
    for (int w = 0; w < 4; w++) begin
      if (!hit && present[set][w] && lines[set][w] == line) begin
        hit = 1'b1;
        pos = w;
      end
    end
    for (int w = pos; w > 0; w--) begin
      lines[set][w] = lines[set][w-1];
      present[set][w] = present[set][w-1];
    end
    lines[set][0] = line;
    present[set][0] = 1'b1;
  endtask

  task automatic clear_model();
    for (int s = 0; s < 16; s++) begin
      for (int w = 0; w < 4; w++) begin
        present[s][w] = 1'b0;
      end
    end
  endtask

  task automatic start_test(input string name, input bit exp_hit);
    cur_name = name;
    tbl_hit = exp_hit;
  endtask

  // flush has priority, so no request may be taken meanwhile
  task automatic check_flush();
    if (l0_ready_out) begin
      fail_count++;
      $display("Mismatch %s l0_ready_out: expected 0 actual 1", cur_name);
      $display("FAIL %s", cur_name);
    end else begin
      pass_count++;
      $display("PASS %s (flush)", cur_name);
    end
  endtask

  task automatic finish_test();
    bit ok;
    bit act_hit;
    logic [LINE_BITS-1:0] exp_line;
    ok = 1'b1;
    act_hit = (lc_reqs == 0);
    exp_line = pattern_line(req_line);
    if (act_hit != pred_hit) begin
      $display("Mismatch %s hit: expected %0d actual %0d", cur_name, pred_hit, act_hit);
      ok = 1'b0;
    end
    if (pred_hit != tbl_hit) begin
      $display("%s: the table and the LRU model disagree on hit or miss", cur_name);
      ok = 1'b0;
    end
    if (lc_reqs > 1) begin
      $display("%s: more than one request went to the lower cache", cur_name);
      ok = 1'b0;
    end
    if (!lc_addr_ok) begin
      $display("Mismatch %s lc_addr: expected %h actual %h", cur_name, req_line, lc_seen);
      ok = 1'b0;
    end
    if (lc_rdy_bad) begin
      $display("Mismatch %s lc_ready_out: expected %0d actual %0d", cur_name, lc_rdy_exp,
        !lc_rdy_exp);
      ok = 1'b0;
    end
    lc_rdy_bad = 1'b0;
    if (act_hit && rise_lat != 3) begin
      $display("Mismatch %s hit latency: expected 3 actual %0d", cur_name, rise_lat);
      ok = 1'b0;
    end
    if (l0_addr_out != {32'h0, req_line}) begin
      $display("Mismatch %s l0_addr: expected %h actual %h", cur_name, {32'h0, req_line},
        l0_addr_out);
      ok = 1'b0;
    end
    if (l0_value_out != exp_line) begin
      $display("Mismatch %s l0_value: expected %h actual %h", cur_name, exp_line, l0_value_out);
      ok = 1'b0;
    end
    if (ok) begin
      pass_count++;
      $display("PASS %s (%s)", cur_name, act_hit ? "hit" : "miss");
    end else begin
      fail_count++;
      $display("FAIL %s", cur_name);
    end
  endtask

  always @(posedge clk_in) begin
    if (!rst_N_in) begin
      clear_model();
      in_flight = 1'b0;
      lc_prev = 1'b0;
      lc_waiting = 1'b0;
      lc_rdy_bad = 1'b0;
      pass_count = 0;
      fail_count = 0;
    end else begin
      if (flush_in) begin
        clear_model();
        check_flush();
      end
      if (in_flight) begin
        cycles++;
      end
      // lc_ready_out is high from the request transfer until the line arrives
      if (lc_ready_out != lc_waiting && !lc_rdy_bad) begin
        lc_rdy_bad = 1'b1;
        lc_rdy_exp = lc_waiting;
      end
      if (l0_valid_in && l0_ready_out) begin
        req_line = l0_addr_in[31:0] & 32'hffff_ffc0;
        model_access(req_line, pred_hit);
        in_flight = 1'b1;
        cycles = 0;
        rise_lat = -1;
        lc_reqs = 0;
        lc_addr_ok = 1'b1;
      end
      // each rise of lc_valid_out is a new miss request
      if (lc_valid_out && !lc_prev) begin
        lc_reqs++;
      end
      lc_prev = lc_valid_out;
      if (lc_valid_out && lc_ready_in) begin
        lc_seen = lc_addr_out;
        lc_waiting = 1'b1;
        if (lc_addr_out != req_line) begin
          lc_addr_ok = 1'b0;
        end
      end
      if (lc_valid_in && lc_ready_out) begin
        lc_waiting = 1'b0;
      end
      if (in_flight && l0_valid_out && l0_ready_in) begin
        in_flight = 1'b0;
        finish_test();
      end
    end
  end

  // rise of l0_valid_out, counted in edges after acceptance
  always @(negedge clk_in) begin
    if (in_flight && l0_valid_out && rise_lat < 0) begin
      rise_lat = cycles;
    end
  end

endmodule : l1_icache_checker

`default_nettype wire

/* tb/l1_icache_properties.sv */
// ======================================================================
// Handshake properties for the L1 instruction cache
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module l1_icache_properties #(
  parameter int LINE_BITS = 512,
  parameter int PADDR_BITS = 32
) (
  input logic clk_in,
  input logic rst_N_in,
  input logic l0_ready_out,
  input logic l0_valid_out,
  input logic [cache_pkg::L0_ADDR_BITS-1:0] l0_addr_out,
  input logic [LINE_BITS-1:0] l0_value_out,
  input logic l0_ready_in,
  input logic lc_valid_out,
  input logic [PADDR_BITS-1:0] lc_addr_out,
  input logic lc_ready_in
);

  // number of failed assertions
  int violations = 0;

  // response held until L0 takes it
  l0_hold: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    (l0_valid_out && !l0_ready_in) |=>
      (l0_valid_out && $stable(l0_addr_out) && $stable(l0_value_out)))
    else begin
      $error("l0 response changed or dropped before ready");
      violations++;
    end

  // miss request held until the lower cache takes it
  lc_hold: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    (lc_valid_out && !lc_ready_in) |=> (lc_valid_out && $stable(lc_addr_out)))
    else begin
      $error("lc request changed or dropped before ready");
      violations++;
    end

  no_accept_pending: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    l0_valid_out |-> !l0_ready_out)
    else begin
      $error("l0_ready_out high while a response is pending");
      violations++;
    end

  one_channel: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    !(lc_valid_out && l0_valid_out))
    else begin
      $error("lc_valid_out and l0_valid_out high together");
      violations++;
    end

endmodule : l1_icache_properties

`default_nettype wire

/* tb/tb_l1_icache.sv */
// ======================================================================
// L1 instruction cache testbench
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_l1_icache;

  localparam int LINE_BITS = 8 * cache_pkg::DEF_BLOCK_BYTES;
  localparam int PADDR_BITS = cache_pkg::DEF_PADDR_BITS;
  localparam int LIMIT = 200;

  logic clk_in;
  logic rst_N_in;
  logic flush_in;
  logic l0_valid_in;
  logic [cache_pkg::L0_ADDR_BITS-1:0] l0_addr_in;
  logic l0_ready_out;
  logic l0_valid_out;
  logic [cache_pkg::L0_ADDR_BITS-1:0] l0_addr_out;
  logic [LINE_BITS-1:0] l0_value_out;
  logic l0_ready_in;
  logic lc_valid_out;
  logic [PADDR_BITS-1:0] lc_addr_out;
  logic lc_ready_in;
  logic lc_valid_in;
  logic [PADDR_BITS-1:0] lc_addr_in;
  logic [LINE_BITS-1:0] lc_value_in;
  logic lc_ready_out;
  int pass_count;
  int fail_count;

  // stimulus table
  string t_name [$];
  bit t_flush [$];
  logic [cache_pkg::L0_ADDR_BITS-1:0] t_addr [$];
  int t_lc_stall [$];
  int t_l0_stall [$];
  bit t_hit [$];

  int seed;
  bit timed_out;

  l1_icache_top dut (.*);

  bind l1_icache_top l1_icache_properties #(
    .LINE_BITS(8 * B),
    .PADDR_BITS(PADDR_BITS)
  ) u_props (.*);

  l1_icache_checker #(
    .LINE_BITS(LINE_BITS),
    .PADDR_BITS(PADDR_BITS)
  ) chk (.*);

  initial begin
    clk_in = 1'b0;
    forever #5 clk_in = ~clk_in;
  end

  task automatic add_entry(input string name, input bit flush,
                           input logic [cache_pkg::L0_ADDR_BITS-1:0] addr,
                           input int lc_stall, input int l0_stall, input bit hit);
    t_name.push_back(name);
    t_flush.push_back(flush);
    t_addr.push_back(addr);
    t_lc_stall.push_back(lc_stall);
    t_l0_stall.push_back(l0_stall);
    t_hit.push_back(hit);
  endtask

  // lower cache line: word k is {line address, k}
  function automatic logic [LINE_BITS-1:0] lc_line(input logic [31:0] line_addr);
    logic [LINE_BITS-1:0] v;
    for (int k = 0; k < LINE_BITS / 64; k++) begin
      v[64*k +: 64] = {line_addr, 32'(k)};
    end
    return v;
  endfunction

  task automatic serve_lc(input int stall, output bit ok);
    int t;
    logic [31:0] line_addr;
    ok = 1'b0;
    repeat (stall + int'($unsigned($random(seed)) % 3)) @(posedge clk_in);
    line_addr = lc_addr_out;
    lc_ready_in <= 1'b1;
    @(posedge clk_in);
    lc_ready_in <= 1'b0;
    repeat (int'($unsigned($random(seed)) % 3)) @(posedge clk_in);
    lc_valid_in <= 1'b1;
    lc_addr_in <= line_addr;
    lc_value_in <= lc_line(line_addr);
    t = 0;
    while (!ok && t < LIMIT) begin
      @(posedge clk_in);
      t++;
      if (lc_ready_out) ok = 1'b1;
    end
    lc_valid_in <= 1'b0;
    if (!ok) $display("timeout: the cache never took the line from the lower cache");
  endtask

  task automatic run_read(input int i, output bit ok);
    int t;
    bit got_lc;
    bit got_rsp;
    bit lc_ok;
    ok = 1'b0;
    got_lc = 1'b0;
    got_rsp = 1'b0;
    @(posedge clk_in);
    chk.start_test(t_name[i], t_hit[i]);
    l0_valid_in <= 1'b1;
    l0_addr_in <= t_addr[i];
    t = 0;
    while (!ok && t < LIMIT) begin
      @(posedge clk_in);
      t++;
      if (l0_ready_out) ok = 1'b1;
    end
    l0_valid_in <= 1'b0;
    if (!ok) begin
      $display("timeout: %s was never accepted", t_name[i]);
      return;
    end
    t = 0;
    while (!got_lc && !got_rsp && t < LIMIT) begin
      @(posedge clk_in);
      t++;
      got_lc = lc_valid_out;
      got_rsp = l0_valid_out;
    end
    if (got_lc) begin
      serve_lc(t_lc_stall[i], lc_ok);
      if (!lc_ok) begin
        ok = 1'b0;
        return;
      end
      t = 0;
      while (!got_rsp && t < LIMIT) begin
        @(posedge clk_in);
        t++;
        got_rsp = l0_valid_out;
      end
    end
    if (!got_rsp) begin
      $display("timeout: no response for %s", t_name[i]);
      ok = 1'b0;
      return;
    end
    repeat (t_l0_stall[i]) @(posedge clk_in);
    l0_ready_in <= 1'b1;
    ok = 1'b0;
    t = 0;
    while (!ok && t < LIMIT) begin
      @(posedge clk_in);
      t++;
      if (l0_valid_out && l0_ready_in) ok = 1'b1;
    end
    l0_ready_in <= 1'b0;
    if (!ok) $display("timeout: response for %s was never transferred", t_name[i]);
  endtask

  task automatic run_flush(input int i);
    @(posedge clk_in);
    chk.start_test(t_name[i], t_hit[i]);
    flush_in <= 1'b1;
    @(posedge clk_in);
    flush_in <= 1'b0;
  endtask

  initial begin
    bit ok;
    seed = 32'hd2b;
    timed_out = 1'b0;
    rst_N_in = 1'b0;
    flush_in = 1'b0;
    l0_valid_in = 1'b0;
    l0_addr_in = '0;
    l0_ready_in = 1'b0;
    lc_ready_in = 1'b0;
    lc_valid_in = 1'b0;
    lc_addr_in = '0;
    lc_value_in = '0;
    // set 2 lines are 0x0080 + n * 0x400
    add_entry("cold_miss", 1'b0, 64'h0084, 0, 0, 1'b0);
    add_entry("same_line", 1'b0, 64'h0084, 0, 0, 1'b1);
    add_entry("other_offset", 1'b0, 64'h00bc, 0, 0, 1'b1);
    add_entry("fill_b", 1'b0, 64'h0480, 1, 0, 1'b0);
    add_entry("fill_c", 1'b0, 64'h0880, 0, 1, 1'b0);
    add_entry("fill_d", 1'b0, 64'h0c80, 2, 0, 1'b0);
    add_entry("touch_a", 1'b0, 64'h0090, 0, 0, 1'b1);
    add_entry("evict_b", 1'b0, 64'h1080, 0, 0, 1'b0);
    add_entry("a_survives", 1'b0, 64'h0080, 0, 0, 1'b1);
    add_entry("b_evicted", 1'b0, 64'h0480, 0, 0, 1'b0);
    add_entry("flush_all", 1'b1, 64'h0, 0, 0, 1'b0);
    add_entry("after_flush", 1'b0, 64'h0080, 0, 0, 1'b0);
    add_entry("lc_stall", 1'b0, 64'h2000, 5, 0, 1'b0);
    add_entry("l0_stall", 1'b0, 64'h2010, 0, 4, 1'b1);
    add_entry("both_stall", 1'b0, 64'h3040, 3, 3, 1'b0);
    repeat (2) @(posedge clk_in);
    rst_N_in <= 1'b1;
    for (int i = 0; i < t_name.size(); i++) begin
      if (t_flush[i]) begin
        run_flush(i);
      end else begin
        run_read(i, ok);
        if (!ok) begin
          timed_out = 1'b1;
          break;
        end
      end
    end
    @(posedge clk_in);
    $display("%0d tests passed, %0d failed, %0d handshake assertion failures", pass_count,
      fail_count, dut.u_props.violations);
    if (timed_out || fail_count != 0 || dut.u_props.violations != 0 ||
        pass_count != t_name.size()) begin
      $display("TEST FAILED");
    end else begin
      $display("TEST OK");
    end
    $finish;
  end

endmodule : tb_l1_icache

`default_nettype wire
